// ==== tuple_merger.f ====
common/merge_data_pkg.sv
common/merge_ctrl_pkg.sv
source/tuple_fifo.sv
merger/merge_control.sv
merger/bitonic_merge_8.sv
merger/tuple_merger.sv
bench/merger_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the tuple merger testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE=sim.log

verilator --binary --timescale 1ns/1ps -Wno-fatal \
   -f tuple_merger.f --top-module merger_tb \
   -Mdir "$BUILD_DIR" -o merger_tb_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

"$BUILD_DIR/merger_tb_sim" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG_FILE"; then
   exit 0
else
   echo "Pass message not found in $LOG_FILE"
   exit 1
fi

// ==== bench/merger_tb.sv ====
`default_nettype none

module merger_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import merge_data_pkg::*;

   localparam int RESET_CYCLES  = 16;
   localparam int SETTLE_CYCLES = 20;  // Quiet cycles that must show no extra output
   // Input tuples over all tests including terminators
   localparam int TOTAL_TUPLES  = 12 + 5 + 14 + 82 + 23;
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + 200 * TOTAL_TUPLES;

   logic   i_clk;
   logic   i_reset;
   tuple_t i_in_a_tuple = '0;
   logic   i_in_a_empty = 1'b1;
   tuple_t i_in_b_tuple = '0;
   logic   i_in_b_empty = 1'b1;
   logic   i_out_ready  = 1'b0;
   logic   o_in_a_read;
   logic   o_in_b_read;
   logic   o_out_write;
   tuple_t o_out_tuple;

   tuple_t src_a[$];       // Upstream FIFO contents for side A
   tuple_t src_b[$];
   tuple_t got[$];         // Tuples written out by the DUT
   tuple_t exp_q[$];
   key_t   model_keys[$];  // Keys of the current pair in ascending order
   logic   ready_random = 1'b0;

   tuple_merger u_dut (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_in_a_tuple (i_in_a_tuple),
      .i_in_a_empty (i_in_a_empty),
      .o_in_a_read  (o_in_a_read),
      .i_in_b_tuple (i_in_b_tuple),
      .i_in_b_empty (i_in_b_empty),
      .o_in_b_read  (o_in_b_read),
      .i_out_ready  (i_out_ready),
      .o_out_write  (o_out_write),
      .o_out_tuple  (o_out_tuple)
   );

   initial begin
      i_clk = 1'b0;
      forever #2 i_clk = ~i_clk;
   end

   // The read strobe takes the head that was shown before this edge
   always @(posedge i_clk) begin
      if (o_in_a_read && src_a.size() > 0)
         void'(src_a.pop_front());
      i_in_a_empty <= (src_a.size() == 0);
      i_in_a_tuple <= (src_a.size() > 0) ? src_a[0] : '0;
   end

   always @(posedge i_clk) begin
      if (o_in_b_read && src_b.size() > 0)
         void'(src_b.pop_front());
      i_in_b_empty <= (src_b.size() == 0);
      i_in_b_tuple <= (src_b.size() > 0) ? src_b[0] : '0;
   end

   always @(posedge i_clk) begin
      if (ready_random)
         i_out_ready <= 1'($urandom % 2);
      else
         i_out_ready <= 1'b1;
   end

   always @(posedge i_clk) begin
      if (!i_reset && o_out_write)
         got.push_back(o_out_tuple);
   end

   task automatic check(input string test_name, input logic [63:0] expected,
                        input logic [63:0] actual);
      if (expected !== actual) begin
         $display("CHECK FAILED %s: expected %h, actual %h", test_name, expected, actual);
         $display("CHECKS FAILED");
         $fatal(1, "Stopping at the first mismatch");
      end
   endtask

   task automatic insert_sorted(input key_t k);
      int pos;
      pos = model_keys.size();
      while (pos > 0 && model_keys[pos-1] > k)
         pos--;
      model_keys.insert(pos, k);
   endtask

   // Builds one ascending stream, each key stepping up by less than step
   task automatic push_stream(input int n_tuples, input int step, input bit to_b);
      tuple_t t;
      int     cur;
      cur = 1 + int'($urandom % step);
      for (int i = 0; i < n_tuples; i++) begin
         for (int j = 0; j < TUPLE_KEYS; j++) begin
            t[j] = key_t'(cur);
            insert_sorted(key_t'(cur));
            cur += int'($urandom % step);
         end
         if (to_b)
            src_b.push_back(t);
         else
            src_a.push_back(t);
      end
      if (to_b)
         src_b.push_back('0);  // Terminator
      else
         src_a.push_back('0);
   endtask

   // Expected output is all keys sorted, four per tuple, then one zero tuple
   task automatic send_pair(input int n_a, input int n_b, input int step);
      tuple_t t;
      push_stream(n_a, step, 1'b0);
      push_stream(n_b, step, 1'b1);
      for (int i = 0; i < model_keys.size(); i += TUPLE_KEYS) begin
         for (int j = 0; j < TUPLE_KEYS; j++)
            t[j] = model_keys[i+j];
         exp_q.push_back(t);
      end
      exp_q.push_back('0);
      model_keys.delete();
   endtask

   task automatic collect_and_compare(input string test_name);
      while (got.size() < exp_q.size())
         @(posedge i_clk);
      repeat (SETTLE_CYCLES) @(posedge i_clk);
      check({test_name, " output count"}, exp_q.size(), got.size());
      check({test_name, " inputs drained"}, 0, src_a.size() + src_b.size());
      for (int i = 0; i < exp_q.size(); i++)
         check($sformatf("%s tuple %0d", test_name, i), exp_q[i], got[i]);
      got.delete();
      exp_q.delete();
   endtask

   task automatic test_reset_idle();
      repeat (10) begin
         @(negedge i_clk);
         check("reset_idle read a", 0, o_in_a_read);
         check("reset_idle read b", 0, o_in_b_read);
         check("reset_idle write", 0, o_out_write);
      end
   endtask

   task automatic test_random_pair();
      send_pair(5, 5, 400);
      collect_and_compare("random_pair");
   endtask

   task automatic test_one_side_empty();
      send_pair(0, 3, 400);
      collect_and_compare("one_side_empty");
   endtask

   task automatic test_equal_keys();
      send_pair(6, 6, 2);  // Steps of 0 or 1 give long runs of equal keys
      collect_and_compare("equal_keys");
   endtask

   task automatic test_backpressure();
      ready_random = 1'b1;
      send_pair(40, 40, 400);
      collect_and_compare("backpressure");
      ready_random = 1'b0;
   endtask

   task automatic test_back_to_back();
      send_pair(3, 4, 400);
      send_pair(2, 2, 400);
      send_pair(5, 1, 400);
      collect_and_compare("back_to_back");
   endtask

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge i_clk);
      $display("Timeout: the merge node did not finish the tests in %0d cycles",
               WATCHDOG_CYCLES);
      $display("CHECKS FAILED");
      $fatal(1, "Watchdog expired");
   end

   initial begin
      void'($urandom(32'h95733e2c));
      i_reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge i_clk);
      i_reset <= 1'b0;
      test_reset_idle();
      test_random_pair();
      test_one_side_empty();
      test_equal_keys();
      test_backpressure();
      test_back_to_back();
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== merger/tuple_merger.sv ====
`default_nettype none

module tuple_merger (
   input  wire                    i_clk,
   input  wire                    i_reset,
   input  merge_data_pkg::tuple_t i_in_a_tuple,
   input  wire                    i_in_a_empty,
   output logic                   o_in_a_read,
   input  merge_data_pkg::tuple_t i_in_b_tuple,
   input  wire                    i_in_b_empty,
   output logic                   o_in_b_read,
   input  wire                    i_out_ready,
   output logic                   o_out_write,
   output merge_data_pkg::tuple_t o_out_tuple
);

   import merge_data_pkg::*;
   import merge_ctrl_pkg::*;

   logic ready_q;  // Downstream ready delayed by one cycle

   tuple_t head_a;
   tuple_t head_b;
   tuple_t head_sel;
   tuple_t emit_tuple;

   logic empty_a;
   logic empty_b;
   logic empty_out;
   logic full_a;
   logic full_b;
   logic almost_full_out;
   logic deq_a;
   logic deq_b;
   logic sel_b;
   logic emit_valid;

   stage_ctrl_t stage;

   always_ff @(posedge i_clk) begin
      if (i_reset)
         ready_q <= 1'b0;
      else
         ready_q <= i_out_ready;
   end

   // Upstream head is taken on the same edge as the read strobe
   assign o_in_a_read = ~i_in_a_empty & ~full_a & ~i_reset;
   assign o_in_b_read = ~i_in_b_empty & ~full_b & ~i_reset;
   assign o_out_write = ready_q & ~empty_out;

   assign head_sel = sel_b ? head_b : head_a;

   tuple_fifo fifo_a (
      .i_clk         (i_clk),
      .i_reset       (i_reset),
      .i_data        (i_in_a_tuple),
      .i_enq         (o_in_a_read),
      .i_deq         (deq_a),
      .o_data        (head_a),
      .o_empty       (empty_a),
      .o_full        (full_a),
      .o_almost_full ()
   );

   tuple_fifo fifo_b (
      .i_clk         (i_clk),
      .i_reset       (i_reset),
      .i_data        (i_in_b_tuple),
      .i_enq         (o_in_b_read),
      .i_deq         (deq_b),
      .o_data        (head_b),
      .o_empty       (empty_b),
      .o_full        (full_b),
      .o_almost_full ()
   );

   // Stall early enough that the tuple already in the network still has a slot
   merge_control u_control (
      .i_clk     (i_clk),
      .i_reset   (i_reset),
      .i_head_a  (head_a),
      .i_head_b  (head_b),
      .i_empty_a (empty_a),
      .i_empty_b (empty_b),
      .i_stall   (almost_full_out),
      .o_deq_a   (deq_a),
      .o_deq_b   (deq_b),
      .o_sel_b   (sel_b),
      .o_stage   (stage)
   );

   bitonic_merge_8 u_network (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_tuple      (head_sel),
      .i_stage      (stage),
      .o_emit_tuple (emit_tuple),
      .o_emit_valid (emit_valid)
   );

   tuple_fifo fifo_out (
      .i_clk         (i_clk),
      .i_reset       (i_reset),
      .i_data        (emit_tuple),
      .i_enq         (emit_valid),
      .i_deq         (o_out_write),
      .o_data        (o_out_tuple),
      .o_empty       (empty_out),
      .o_full        (),
      .o_almost_full (almost_full_out)
   );

endmodule

`default_nettype wire

// ==== merger/bitonic_merge_8.sv ====
`default_nettype none

module bitonic_merge_8 (
   input  wire                         i_clk,
   input  wire                         i_reset,
   input  merge_data_pkg::tuple_t      i_tuple,
   input  merge_ctrl_pkg::stage_ctrl_t i_stage,
   output merge_data_pkg::tuple_t      o_emit_tuple,
   output logic                        o_emit_valid
);

   import merge_data_pkg::*;

   tuple_t carry_q;   // Four largest keys merged so far, ascending
   tuple_t merged_lo;
   tuple_t merged_hi;

   // The incoming tuple ascends and the carry is laid in reverse, so the eight keys
   // form one bitonic sequence. Three half-cleaner levels then sort it ascending.
   always_comb begin
      key_t seq [2*TUPLE_KEYS];
      key_t lo;
      key_t hi;

      for (int i = 0; i < TUPLE_KEYS; i++) begin
         seq[i]                  = i_tuple[i];
         seq[2*TUPLE_KEYS-1-i]   = carry_q[i];
      end

      // Distance 4, then 2, then 1
      for (int d = TUPLE_KEYS; d > 0; d = d / 2) begin
         for (int i = 0; i < 2*TUPLE_KEYS; i++) begin
            if ((i & d) == 0) begin
               lo = (seq[i] <= seq[i+d]) ? seq[i] : seq[i+d];
               hi = (seq[i] <= seq[i+d]) ? seq[i+d] : seq[i];
               seq[i]   = lo;
               seq[i+d] = hi;
            end
         end
      end

      for (int i = 0; i < TUPLE_KEYS; i++) begin
         merged_lo[i] = seq[i];
         merged_hi[i] = seq[TUPLE_KEYS+i];
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset)
         o_emit_valid <= 1'b0;
      else
         o_emit_valid <= (i_stage.valid & ~i_stage.load_only) | i_stage.flush | i_stage.term;
   end

   always_ff @(posedge i_clk) begin
      if (i_stage.term) begin
         o_emit_tuple <= '0;
         carry_q      <= '0;  // Nothing leaks into the next stream pair
      end else if (i_stage.flush) begin
         o_emit_tuple <= carry_q;
      end else if (i_stage.valid) begin
         if (i_stage.load_only) begin
            carry_q <= i_tuple;  // First tuple of a pair only seeds the carry
         end else begin
            o_emit_tuple <= merged_lo;
            carry_q      <= merged_hi;
         end
      end
   end

endmodule

`default_nettype wire

// ==== merger/merge_control.sv ====
`default_nettype none

module merge_control (
   input  wire                         i_clk,
   input  wire                         i_reset,
   input  merge_data_pkg::tuple_t      i_head_a,
   input  merge_data_pkg::tuple_t      i_head_b,
   input  wire                         i_empty_a,
   input  wire                         i_empty_b,
   input  wire                         i_stall,
   output logic                        o_deq_a,
   output logic                        o_deq_b,
   output logic                        o_sel_b,
   output merge_ctrl_pkg::stage_ctrl_t o_stage
);

   import merge_data_pkg::*;
   import merge_ctrl_pkg::*;

   merge_state_e state_q;
   merge_state_e state_d;

   key_t first_a;
   key_t first_b;
   logic end_a;   // Head of A is the zero tuple
   logic end_b;
   logic data_a;  // Head of A holds real keys
   logic data_b;

   assign first_a = i_head_a[0];
   assign first_b = i_head_b[0];
   assign end_a   = ~i_empty_a & (i_head_a == '0);
   assign end_b   = ~i_empty_b & (i_head_b == '0);
   assign data_a  = ~i_empty_a & ~end_a;
   assign data_b  = ~i_empty_b & ~end_b;

   always_comb begin
      state_d = state_q;
      o_deq_a = 1'b0;
      o_deq_b = 1'b0;
      o_sel_b = 1'b0;
      o_stage = '0;

      if (!i_stall) begin
         case (state_q)
            IDLE, RUN: begin
               if (data_a && (data_b || end_b)) begin
                  // B wins only on a strictly smaller first key
                  if (data_b && (first_b < first_a)) begin
                     o_sel_b = 1'b1;
                     o_deq_b = 1'b1;
                  end else begin
                     o_deq_a = 1'b1;
                  end
                  o_stage.valid     = 1'b1;
                  o_stage.load_only = (state_q == IDLE);
                  state_d           = RUN;
               end else if (data_b && end_a) begin
                  o_sel_b           = 1'b1;
                  o_deq_b           = 1'b1;
                  o_stage.valid     = 1'b1;
                  o_stage.load_only = (state_q == IDLE);
                  state_d           = RUN;
               end else if (end_a && end_b) begin
                  // A's terminator leaves now, B's leaves in TERM
                  o_deq_a = 1'b1;
                  state_d = (state_q == RUN) ? FLUSH : TERM;
               end
               // Any other mix means one side has not arrived yet, so wait
            end
            FLUSH: begin
               o_stage.flush = 1'b1;
               state_d       = TERM;
            end
            TERM: begin
               o_deq_b      = 1'b1;  // B still holds its terminator at the head
               o_stage.term = 1'b1;
               state_d      = IDLE;
            end
            default: state_d = IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset)
         state_q <= IDLE;
      else
         state_q <= state_d;
   end

endmodule

`default_nettype wire

// ==== source/tuple_fifo.sv ====
`default_nettype none

module tuple_fifo #(
   parameter int DEPTH = merge_data_pkg::FIFO_DEPTH
) (
   input  wire                    i_clk,
   input  wire                    i_reset,
   input  merge_data_pkg::tuple_t i_data,
   input  wire                    i_enq,
   input  wire                    i_deq,
   output merge_data_pkg::tuple_t o_data,
   output logic                   o_empty,
   output logic                   o_full,
   output logic                   o_almost_full
);

   import merge_data_pkg::*;

   tuple_t mem [DEPTH];

   logic [$clog2(DEPTH)-1:0]   rd_ptr;
   logic [$clog2(DEPTH)-1:0]   wr_ptr;
   logic [$clog2(DEPTH+1)-1:0] count;
   logic                       do_enq;
   logic                       do_deq;

   assign o_empty       = (count == 0);
   assign o_full        = (count == DEPTH);
   assign o_almost_full = (count >= DEPTH - 2);  // Two or fewer slots left

   // Writes to a full FIFO and reads from an empty one are dropped
   assign do_enq = i_enq & ~o_full;
   assign do_deq = i_deq & ~o_empty;

   // Head word is visible without a read request
   assign o_data = mem[rd_ptr];

   always_ff @(posedge i_clk) begin
      if (do_enq) begin
         mem[wr_ptr] <= i_data;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_enq) begin
            if (wr_ptr == DEPTH - 1)
               wr_ptr <= '0;
            else
               wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_deq) begin
            if (rd_ptr == DEPTH - 1)
               rd_ptr <= '0;
            else
               rd_ptr <= rd_ptr + 1'b1;
         end
         if (do_enq && !do_deq)
            count <= count + 1'b1;
         else if (do_deq && !do_enq)
            count <= count - 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== common/merge_ctrl_pkg.sv ====
`default_nettype none

package merge_ctrl_pkg;

   // Sequencing of one stream pair through the merge node
   typedef enum logic [1:0] {
      IDLE  = 2'd0,  // No carry held yet
      RUN   = 2'd1,  // Carry holds the four largest keys seen so far
      FLUSH = 2'd2,  // Both streams ended, emit the carry
      TERM  = 2'd3   // Emit the zero tuple that ends the output stream
   } merge_state_e;

   // Control that travels alongside a tuple into the bitonic network
   typedef struct packed {
      logic valid;      // A tuple enters the network this cycle
      logic load_only;  // Tuple becomes the carry, nothing is emitted
      logic flush;      // Emit the carry unchanged
      logic term;       // Emit a zero tuple and clear the carry
   } stage_ctrl_t;

endpackage

`default_nettype wire

// ==== common/merge_data_pkg.sv ====
`default_nettype none

package merge_data_pkg;

   // One key is an unsigned sort value, and zero is reserved for the terminator
   localparam int KEY_W = 16;

   // Keys per tuple. Index 0 always holds the smallest key of the tuple
   localparam int TUPLE_KEYS = 4;

   // Depth of the input and output tuple FIFOs inside the merge node
   localparam int FIFO_DEPTH = 16;

   typedef logic [KEY_W-1:0] key_t;

   // A tuple travels as one 64-bit word on every interface
   typedef key_t [TUPLE_KEYS-1:0] tuple_t;

endpackage

`default_nettype wire
